// ==== axil_regs_top.f ====
axil_regs_pkg.sv
axil_slave_fe.sv
axil_addr_decode.sv
axil_reg_bank.sv
axil_regs_top.sv
axil_regs_props.sv
axil_regs_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build with Verilator, run, and judge the run from the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log

verilator --binary --timing --assert --top-module axil_regs_tb \
    -f axil_regs_top.f -o axil_regs_sim > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }

# A non-zero exit (assertion or fatal) counts as a failed run
./obj_dir/axil_regs_sim > sim.log 2>&1 || echo "ERRORS FOUND" >> sim.log
cat sim.log

grep -q "ERRORS FOUND" sim.log && { echo "simulation failed"; exit 1; } \
    || { echo "simulation passed"; exit 0; }

// ==== axil_regs_tb.sv ====
`timescale 1ns/1ps

module axil_regs_tb;

    import axil_regs_pkg::*;

    localparam int                NUM_SCR   = 8;
    localparam int                NUM_WORDS = NUM_SCR + 2;
    localparam logic [data_w-1:0] ID_VAL    = 32'h5a1e_0c3d;

    logic              ACLK;
    logic              ARESETn;
    logic [addr_w-1:0] awaddr;
    logic [2:0]        awprot;
    logic              awvalid;
    logic              awready;
    logic [data_w-1:0] wdata;
    logic [strb_w-1:0] wstrb;
    logic              wvalid;
    logic              wready;
    resp_t             bresp;
    logic              bvalid;
    logic              bready;
    logic [addr_w-1:0] araddr;
    logic [2:0]        arprot;
    logic              arvalid;
    logic              arready;
    logic [data_w-1:0] rdata;
    resp_t             rresp;
    logic              rvalid;
    logic              rready;

    // Expected contents of every word in the map
    logic [data_w-1:0] regs_m [NUM_WORDS];

    axil_regs_top #(
        .NUM_SCRATCH (NUM_SCR),
        .ID_VALUE    (ID_VAL)
    ) dut_i (
        .ACLK    (ACLK),
        .ARESETn (ARESETn),
        .awaddr  (awaddr),
        .awprot  (awprot),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .araddr  (araddr),
        .arprot  (arprot),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready)
    );

    always #10 ACLK = ~ACLK;

    // ==================================================
    // Reporting
    // ==================================================

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("ERRORS FOUND");
        $fatal(1, "stopping at the first failure");
    endtask

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("error: %s = 0x%08h, expected 0x%08h", name, got, exp));
        end
    endtask

    // ==================================================
    // Register model
    // ==================================================

    function automatic resp_t expect_wr(input wr_req_t req);
        int word;
        word = int'(req.addr[addr_w-1:2]);
        if (word >= NUM_WORDS) return DECERR;
        if (word == 0) return SLVERR;
        if (word == 1 && !req.prot[0]) return SLVERR;
        return OKAY;
    endfunction

    function automatic logic [data_w-1:0] strb_mask(input logic [strb_w-1:0] strb);
        return {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
    endfunction

    function automatic wr_req_t make_req(input logic [addr_w-1:0] addr,
                                         input logic [data_w-1:0] data,
                                         input logic [strb_w-1:0] strb,
                                         input logic [2:0]        prot);
        wr_req_t req;
        req.addr = addr;
        req.data = data;
        req.strb = strb;
        req.prot = prot;
        return req;
    endfunction

    // Mostly inside the map and sometimes far past it
    function automatic logic [addr_w-1:0] rand_addr();
        int word;
        if ($urandom % 8 == 0) begin
            word = int'($urandom % 1024);
        end else begin
            word = int'($urandom % (NUM_WORDS + 2));
        end
        return {10'(word), 2'($urandom % 4)};
    endfunction

    // ==================================================
    // Bus tasks
    // ==================================================

    // Presents AW first, W first or both together at random
    task automatic write_txn(input wr_req_t req);
        int    order;
        int    n;
        int    lat;
        int    word;
        bit    aw_on;
        bit    w_on;
        bit    aw_done;
        bit    w_done;
        bit    aw_fire;
        bit    w_fire;
        resp_t exp;
        resp_t got;
        exp   = expect_wr(req);
        word  = int'(req.addr[addr_w-1:2]);
        order = int'($urandom % 3);
        repeat (int'($urandom % 3)) @(posedge ACLK);
        @(posedge ACLK);
        awaddr  <= req.addr;
        awprot  <= req.prot;
        wdata   <= req.data;
        wstrb   <= req.strb;
        aw_on   = (order != 1);
        w_on    = (order != 0);
        awvalid <= aw_on;
        wvalid  <= w_on;
        aw_done = 1'b0;
        w_done  = 1'b0;
        n       = 0;
        while (!(aw_done && w_done)) begin
            @(negedge ACLK);
            aw_fire = aw_on && !aw_done && awready;
            w_fire  = w_on && !w_done && wready;
            @(posedge ACLK);
            if (aw_fire) begin
                awvalid <= 1'b0;
                aw_done = 1'b1;
            end
            if (w_fire) begin
                wvalid <= 1'b0;
                w_done = 1'b1;
            end
            // Second half after a random gap
            if (aw_done && !w_on && ($urandom % 2 == 0)) begin
                wvalid <= 1'b1;
                w_on = 1'b1;
            end
            if (w_done && !aw_on && ($urandom % 2 == 0)) begin
                awvalid <= 1'b1;
                aw_on = 1'b1;
            end
            n++;
            if (n > 100) fail_run("timeout waiting for the write address and data to be taken");
        end
        // Loop left on the write-accept edge
        lat = 0;
        @(negedge ACLK);
        while (!bvalid) begin
            lat++;
            if (lat > 100) fail_run("timeout waiting for bvalid");
            @(posedge ACLK);
            bready <= ($urandom % 4) != 0;
            @(negedge ACLK);
        end
        check_val("bvalid latency", 32'(lat), 32'd3);
        check_val("bresp", 32'(bresp), 32'(exp));
        got = bresp;
        n   = 0;
        while (!bready) begin
            n++;
            if (n > 100) fail_run("timeout waiting for the write response to be taken");
            @(posedge ACLK);
            bready <= ($urandom % 4) != 0;
            @(negedge ACLK);
            check_val("bvalid", 32'(bvalid), 32'd1);
            check_val("bresp", 32'(bresp), 32'(got));
        end
        @(posedge ACLK);
        bready <= 1'b0;
        if (exp == OKAY) begin
            regs_m[word] = (regs_m[word] & ~strb_mask(req.strb)) | (req.data & strb_mask(req.strb));
        end
    endtask

    task automatic read_txn(input logic [addr_w-1:0] addr, input logic [2:0] prot);
        int                n;
        int                lat;
        int                word;
        logic [data_w-1:0] exp_data;
        logic [data_w-1:0] got_data;
        resp_t             exp_resp;
        resp_t             got_resp;
        word = int'(addr[addr_w-1:2]);
        if (word < NUM_WORDS) begin
            exp_data = regs_m[word];
            exp_resp = OKAY;
        end else begin
            exp_data = '0;
            exp_resp = DECERR;
        end
        repeat (int'($urandom % 3)) @(posedge ACLK);
        @(posedge ACLK);
        araddr  <= addr;
        arprot  <= prot;
        arvalid <= 1'b1;
        n = 0;
        @(negedge ACLK);
        while (!arready) begin
            n++;
            if (n > 100) fail_run("timeout waiting for arready");
            @(negedge ACLK);
        end
        @(posedge ACLK);
        arvalid <= 1'b0;
        lat = 0;
        @(negedge ACLK);
        while (!rvalid) begin
            lat++;
            if (lat > 100) fail_run("timeout waiting for rvalid");
            @(posedge ACLK);
            rready <= ($urandom % 4) != 0;
            @(negedge ACLK);
        end
        check_val("rvalid latency", 32'(lat), 32'd3);
        check_val("rdata", rdata, exp_data);
        check_val("rresp", 32'(rresp), 32'(exp_resp));
        got_data = rdata;
        got_resp = rresp;
        n = 0;
        while (!rready) begin
            n++;
            if (n > 100) fail_run("timeout waiting for the read data to be taken");
            @(posedge ACLK);
            rready <= ($urandom % 4) != 0;
            @(negedge ACLK);
            check_val("rvalid", 32'(rvalid), 32'd1);
            check_val("rdata", rdata, got_data);
            check_val("rresp", 32'(rresp), 32'(got_resp));
        end
        @(posedge ACLK);
        rready <= 1'b0;
    endtask

    // ==================================================
    // Main sequence
    // ==================================================

    initial begin
        ACLK    = 1'b0;
        ARESETn = 1'b0;
        awaddr  = '0;
        awprot  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arprot  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        void'($urandom(32'hf722148c));
        regs_m[0] = ID_VAL;
        for (int i = 1; i < NUM_WORDS; i++) begin
            regs_m[i] = '0;
        end
        repeat (5) @(posedge ACLK);
        ARESETn <= 1'b1;

        // ID is read-only
        read_txn(12'h000, 3'b000);
        write_txn(make_req(12'h000, $urandom, 4'hf, 3'b001));
        read_txn(12'h000, 3'b001);

        // Control needs prot[0]
        write_txn(make_req(12'h004, $urandom, 4'hf, 3'b000));
        read_txn(12'h004, 3'b000);
        write_txn(make_req(12'h004, $urandom, 4'hf, 3'b001));
        read_txn(12'h004, 3'b000);

        // Scratch words with random strobes
        for (int i = 0; i < 40; i++) begin
            write_txn(make_req({10'(2 + $urandom % NUM_SCR), 2'b00}, $urandom,
                               4'($urandom), 3'($urandom)));
            read_txn({10'(2 + $urandom % NUM_SCR), 2'b00}, 3'($urandom));
        end

        // Past the end of the map
        for (int i = 0; i < 10; i++) begin
            write_txn(make_req({10'(NUM_WORDS + $urandom % (1024 - NUM_WORDS)), 2'b00},
                               $urandom, 4'($urandom), 3'($urandom)));
            read_txn({10'(NUM_WORDS + $urandom % (1024 - NUM_WORDS)), 2'b00}, 3'($urandom));
        end

        // Mixed random traffic
        for (int i = 0; i < 200; i++) begin
            if ($urandom % 2 == 0) begin
                write_txn(make_req(rand_addr(), $urandom, 4'($urandom), 3'($urandom)));
            end else begin
                read_txn(rand_addr(), 3'($urandom));
            end
        end

        // Final sweep of every word
        for (int i = 0; i < NUM_WORDS; i++) begin
            read_txn({10'(i), 2'b00}, 3'b000);
        end

        $display("NO ERRORS");
        $finish;
    end

endmodule

// ==== axil_regs_props.sv ====
`timescale 1ns/1ps

module axil_regs_props (
    input logic                             ACLK,
    input logic                             ARESETn,
    input logic                             awready,
    input logic                             bvalid,
    input logic                             bready,
    input axil_regs_pkg::resp_t             bresp,
    input logic                             rvalid,
    input logic                             rready,
    input logic [axil_regs_pkg::data_w-1:0] rdata,
    input axil_regs_pkg::resp_t             rresp
);

    // ==================================================
    // Response channel stability
    // ==================================================

    b_hold_a: assert property (@(posedge ACLK) disable iff (!ARESETn)
        bvalid && !bready |=> bvalid && $stable(bresp))
        else $error("bvalid dropped or bresp changed before bready");

    r_hold_a: assert property (@(posedge ACLK) disable iff (!ARESETn)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
        else $error("rvalid dropped or read data changed before rready");

    // No new write address while a response is pending
    aw_block_a: assert property (@(posedge ACLK) disable iff (!ARESETn)
        bvalid |-> !awready)
        else $error("awready high while bvalid is high");

    rst_a: assert property (@(posedge ACLK)
        !ARESETn |=> !bvalid && !rvalid)
        else $error("bvalid or rvalid high after reset");

endmodule

bind axil_regs_top axil_regs_props props_i (
    .ACLK    (ACLK),
    .ARESETn (ARESETn),
    .awready (awready),
    .bvalid  (bvalid),
    .bready  (bready),
    .bresp   (bresp),
    .rvalid  (rvalid),
    .rready  (rready),
    .rdata   (rdata),
    .rresp   (rresp)
);

// ==== axil_regs_top.sv ====
`timescale 1ns/1ps

module axil_regs_top #(
    parameter int                                NUM_SCRATCH = 8,
    parameter logic [axil_regs_pkg::data_w-1:0] ID_VALUE    = 32'h4158_4c01
) (
    input  logic                             ACLK,
    input  logic                             ARESETn,
    input  logic [axil_regs_pkg::addr_w-1:0] awaddr,
    input  logic [2:0]                       awprot,
    input  logic                             awvalid,
    output logic                             awready,
    input  logic [axil_regs_pkg::data_w-1:0] wdata,
    input  logic [axil_regs_pkg::strb_w-1:0] wstrb,
    input  logic                             wvalid,
    output logic                             wready,
    output axil_regs_pkg::resp_t             bresp,
    output logic                             bvalid,
    input  logic                             bready,
    input  logic [axil_regs_pkg::addr_w-1:0] araddr,
    input  logic [2:0]                       arprot,
    input  logic                             arvalid,
    output logic                             arready,
    output logic [axil_regs_pkg::data_w-1:0] rdata,
    output axil_regs_pkg::resp_t             rresp,
    output logic                             rvalid,
    input  logic                             rready
);

    import axil_regs_pkg::*;

    // Front end to decode
    wr_req_t wr_req;
    logic    wr_go;
    rd_req_t rd_req;
    logic    rd_go;

    // Decode to bank
    reg_wr_t dec_wr;
    logic    dec_wr_go;
    reg_rd_t dec_rd;
    logic    dec_rd_go;

    // Bank back to front end
    resp_t   wr_resp;
    logic    wr_done;
    rd_rsp_t rd_rsp;
    logic    rd_done;

    axil_slave_fe fe_i (
        .ACLK    (ACLK),
        .ARESETn (ARESETn),
        .awaddr  (awaddr),
        .awprot  (awprot),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .araddr  (araddr),
        .arprot  (arprot),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready),
        .wr_req  (wr_req),
        .wr_go   (wr_go),
        .rd_req  (rd_req),
        .rd_go   (rd_go),
        .wr_resp (wr_resp),
        .wr_done (wr_done),
        .rd_rsp  (rd_rsp),
        .rd_done (rd_done)
    );

    axil_addr_decode #(
        .NUM_SCRATCH (NUM_SCRATCH)
    ) dec_i (
        .ACLK      (ACLK),
        .ARESETn   (ARESETn),
        .wr_req    (wr_req),
        .wr_go     (wr_go),
        .rd_req    (rd_req),
        .rd_go     (rd_go),
        .dec_wr    (dec_wr),
        .dec_wr_go (dec_wr_go),
        .dec_rd    (dec_rd),
        .dec_rd_go (dec_rd_go)
    );

    axil_reg_bank #(
        .NUM_SCRATCH (NUM_SCRATCH),
        .ID_VALUE    (ID_VALUE)
    ) bank_i (
        .ACLK      (ACLK),
        .ARESETn   (ARESETn),
        .dec_wr    (dec_wr),
        .dec_wr_go (dec_wr_go),
        .dec_rd    (dec_rd),
        .dec_rd_go (dec_rd_go),
        .wr_resp   (wr_resp),
        .wr_done   (wr_done),
        .rd_rsp    (rd_rsp),
        .rd_done   (rd_done)
    );

endmodule

// ==== axil_reg_bank.sv ====
`timescale 1ns/1ps

module axil_reg_bank #(
    parameter int                                NUM_SCRATCH = 8,
    parameter logic [axil_regs_pkg::data_w-1:0] ID_VALUE    = 32'h4158_4c01
) (
    input  logic                   ACLK,
    input  logic                   ARESETn,
    input  axil_regs_pkg::reg_wr_t dec_wr,
    input  logic                   dec_wr_go,
    input  axil_regs_pkg::reg_rd_t dec_rd,
    input  logic                   dec_rd_go,
    output axil_regs_pkg::resp_t   wr_resp,
    output logic                   wr_done,
    output axil_regs_pkg::rd_rsp_t rd_rsp,
    output logic                   rd_done
);

    import axil_regs_pkg::*;

    logic [data_w-1:0] ctrl_q;
    logic [data_w-1:0] scratch_q [NUM_SCRATCH];
    logic [data_w-1:0] rd_data_c;
    logic              wr_en;

    // Replace only the bytes selected by strb
    function automatic logic [data_w-1:0] merge_bytes(
        input logic [data_w-1:0] old_val,
        input logic [data_w-1:0] new_val,
        input logic [strb_w-1:0] strb
    );
        logic [data_w-1:0] res;
        res = old_val;
        for (int b = 0; b < strb_w; b++) begin
            if (strb[b]) begin
                res[8*b +: 8] = new_val[8*b +: 8];
            end
        end
        return res;
    endfunction

    assign wr_en = dec_wr_go && dec_wr.we;

    // ==================================================
    // Register storage
    // ==================================================

    always_ff @(posedge ACLK) begin
        if (!ARESETn) begin
            ctrl_q <= '0;
            for (int i = 0; i < NUM_SCRATCH; i++) begin
                scratch_q[i] <= '0;
            end
        end else if (wr_en) begin
            if (dec_wr.idx == idx_w'(1)) begin
                ctrl_q <= merge_bytes(ctrl_q, dec_wr.data, dec_wr.strb);
            end
            // Scratch words start at index 2
            for (int i = 0; i < NUM_SCRATCH; i++) begin
                if (dec_wr.idx == idx_w'(i + 2)) begin
                    scratch_q[i] <= merge_bytes(scratch_q[i], dec_wr.data, dec_wr.strb);
                end
            end
        end
    end

    // Read mux gives zero on a miss
    always_comb begin
        rd_data_c = '0;
        if (dec_rd.hit) begin
            if (dec_rd.idx == idx_w'(0)) begin
                rd_data_c = ID_VALUE;
            end else if (dec_rd.idx == idx_w'(1)) begin
                rd_data_c = ctrl_q;
            end
            for (int i = 0; i < NUM_SCRATCH; i++) begin
                if (dec_rd.idx == idx_w'(i + 2)) begin
                    rd_data_c = scratch_q[i];
                end
            end
        end
    end

    // ==================================================
    // Results back to the front end
    // ==================================================

    always_ff @(posedge ACLK) begin
        if (!ARESETn) begin
            wr_done <= 1'b0;
            rd_done <= 1'b0;
        end else begin
            wr_done <= dec_wr_go;
            rd_done <= dec_rd_go;
        end
    end

    always_ff @(posedge ACLK) begin
        if (dec_wr_go) begin
            wr_resp <= dec_wr.resp;
        end
        if (dec_rd_go) begin
            rd_rsp.data <= rd_data_c;
            rd_rsp.resp <= dec_rd.resp;
        end
    end

endmodule

// ==== axil_addr_decode.sv ====
`timescale 1ns/1ps

module axil_addr_decode #(
    parameter int NUM_SCRATCH = 8
) (
    input  logic                   ACLK,
    input  logic                   ARESETn,
    input  axil_regs_pkg::wr_req_t wr_req,
    input  logic                   wr_go,
    input  axil_regs_pkg::rd_req_t rd_req,
    input  logic                   rd_go,
    output axil_regs_pkg::reg_wr_t dec_wr,
    output logic                   dec_wr_go,
    output axil_regs_pkg::reg_rd_t dec_rd,
    output logic                   dec_rd_go
);

    import axil_regs_pkg::*;

    // Highest valid word index in the map
    localparam logic [addr_w-3:0] last_word = (addr_w - 2)'(NUM_SCRATCH + 1);

    logic [addr_w-3:0] wr_word;
    logic [addr_w-3:0] rd_word;
    resp_t             wr_code;
    logic              rd_hit;

    // Byte address to word index
    assign wr_word = wr_req.addr[addr_w-1:2];
    assign rd_word = rd_req.addr[addr_w-1:2];
    assign rd_hit  = (rd_word <= last_word);

    // ID is read-only and control needs a privileged access
    always_comb begin
        if (wr_word > last_word) begin
            wr_code = DECERR;
        end else if (wr_word == '0) begin
            wr_code = SLVERR;
        end else if ((wr_word == (addr_w - 2)'(1)) && !wr_req.prot[0]) begin
            wr_code = SLVERR;
        end else begin
            wr_code = OKAY;
        end
    end

    always_ff @(posedge ACLK) begin
        if (!ARESETn) begin
            dec_wr_go <= 1'b0;
            dec_rd_go <= 1'b0;
        end else begin
            dec_wr_go <= wr_go;
            dec_rd_go <= rd_go;
        end
    end

    always_ff @(posedge ACLK) begin
        if (wr_go) begin
            dec_wr.idx  <= wr_word[idx_w-1:0];
            dec_wr.data <= wr_req.data;
            dec_wr.strb <= wr_req.strb;
            dec_wr.we   <= (wr_code == OKAY);
            dec_wr.resp <= wr_code;
        end
        if (rd_go) begin
            dec_rd.idx  <= rd_word[idx_w-1:0];
            dec_rd.hit  <= rd_hit;
            dec_rd.resp <= rd_hit ? OKAY : DECERR;
        end
    end

endmodule

// ==== axil_slave_fe.sv ====
`timescale 1ns/1ps

module axil_slave_fe (
    input  logic                             ACLK,
    input  logic                             ARESETn,
    // Write address channel
    input  logic [axil_regs_pkg::addr_w-1:0] awaddr,
    input  logic [2:0]                       awprot,
    input  logic                             awvalid,
    output logic                             awready,
    // Write data channel
    input  logic [axil_regs_pkg::data_w-1:0] wdata,
    input  logic [axil_regs_pkg::strb_w-1:0] wstrb,
    input  logic                             wvalid,
    output logic                             wready,
    // Write response channel
    output axil_regs_pkg::resp_t             bresp,
    output logic                             bvalid,
    input  logic                             bready,
    // Read address channel
    input  logic [axil_regs_pkg::addr_w-1:0] araddr,
    input  logic [2:0]                       arprot,
    input  logic                             arvalid,
    output logic                             arready,
    // Read data channel
    output logic [axil_regs_pkg::data_w-1:0] rdata,
    output axil_regs_pkg::resp_t             rresp,
    output logic                             rvalid,
    input  logic                             rready,
    // Pipeline side
    output axil_regs_pkg::wr_req_t           wr_req,
    output logic                             wr_go,
    output axil_regs_pkg::rd_req_t           rd_req,
    output logic                             rd_go,
    input  axil_regs_pkg::resp_t             wr_resp,
    input  logic                             wr_done,
    input  axil_regs_pkg::rd_rsp_t           rd_rsp,
    input  logic                             rd_done
);

    // ==================================================
    // Write FSM
    // ==================================================

    typedef enum logic [2:0] {
        ws_rst, ws_idle, ws_addr, ws_data, ws_wait, ws_resp
    } wr_state_t;

    wr_state_t wr_state, wr_state_next;
    logic      aw_hs;
    logic      w_hs;

    assign aw_hs = awvalid && awready;
    assign w_hs  = wvalid && wready;

    always_ff @(posedge ACLK) begin
        if (!ARESETn) begin
            wr_state <= ws_rst;
            wr_go    <= 1'b0;
        end else begin
            wr_state <= wr_state_next;
            // Pulse once when both halves are in
            wr_go    <= (wr_state_next == ws_wait) && (wr_state != ws_wait);
        end
    end

    always_comb begin
        wr_state_next = wr_state;
        case (wr_state)
            ws_rst:  wr_state_next = ws_idle;
            ws_idle: begin
                if (aw_hs && w_hs) begin
                    wr_state_next = ws_wait;
                end else if (aw_hs) begin
                    wr_state_next = ws_addr;
                end else if (w_hs) begin
                    wr_state_next = ws_data;
                end
            end
            ws_addr: if (w_hs) wr_state_next = ws_wait;
            ws_data: if (aw_hs) wr_state_next = ws_wait;
            ws_wait: if (wr_done) wr_state_next = ws_resp;
            ws_resp: if (bready) wr_state_next = ws_idle;
            default: wr_state_next = ws_rst;
        endcase
    end

    assign awready = (wr_state == ws_idle) || (wr_state == ws_data);
    assign wready  = (wr_state == ws_idle) || (wr_state == ws_addr);
    assign bvalid  = (wr_state == ws_resp);

    // Capture each half as its transfer completes
    always_ff @(posedge ACLK) begin
        if (aw_hs) begin
            wr_req.addr <= awaddr;
            wr_req.prot <= awprot;
        end
        if (w_hs) begin
            wr_req.data <= wdata;
            wr_req.strb <= wstrb;
        end
        if ((wr_state == ws_wait) && wr_done) begin
            bresp <= wr_resp;
        end
    end

    // ==================================================
    // Read FSM
    // ==================================================

    typedef enum logic [1:0] {
        rs_rst, rs_idle, rs_wait, rs_resp
    } rd_state_t;

    rd_state_t rd_state, rd_state_next;
    logic      ar_hs;

    assign ar_hs = arvalid && arready;

    always_ff @(posedge ACLK) begin
        if (!ARESETn) begin
            rd_state <= rs_rst;
            rd_go    <= 1'b0;
        end else begin
            rd_state <= rd_state_next;
            rd_go    <= ar_hs;
        end
    end

    always_comb begin
        rd_state_next = rd_state;
        case (rd_state)
            rs_rst:  rd_state_next = rs_idle;
            rs_idle: if (ar_hs) rd_state_next = rs_wait;
            rs_wait: if (rd_done) rd_state_next = rs_resp;
            rs_resp: if (rready) rd_state_next = rs_idle;
            default: rd_state_next = rs_rst;
        endcase
    end

    assign arready = (rd_state == rs_idle);
    assign rvalid  = (rd_state == rs_resp);

    always_ff @(posedge ACLK) begin
        if (ar_hs) begin
            rd_req.addr <= araddr;
            rd_req.prot <= arprot;
        end
        // Held until rready takes it
        if ((rd_state == rs_wait) && rd_done) begin
            rdata <= rd_rsp.data;
            rresp <= rd_rsp.resp;
        end
    end

endmodule

// ==== axil_regs_pkg.sv ====
package axil_regs_pkg;

    // ==================================================
    // Widths
    // ==================================================

    localparam int data_w = 32;
    localparam int addr_w = 12;
    localparam int strb_w = data_w / 8;
    localparam int idx_w  = 5;

    // AXI response codes
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } resp_t;

    // ==================================================
    // Requests from the front end
    // ==================================================

    typedef struct packed {
        logic [addr_w-1:0] addr;
        logic [data_w-1:0] data;
        logic [strb_w-1:0] strb;
        logic [2:0]        prot;
    } wr_req_t;

    typedef struct packed {
        logic [addr_w-1:0] addr;
        logic [2:0]        prot;
    } rd_req_t;

    // ==================================================
    // Decoded accesses and results
    // ==================================================

    // we is only set for OKAY writes
    typedef struct packed {
        logic [idx_w-1:0]  idx;
        logic [data_w-1:0] data;
        logic [strb_w-1:0] strb;
        logic              we;
        resp_t             resp;
    } reg_wr_t;

    typedef struct packed {
        logic [idx_w-1:0] idx;
        logic             hit;
        resp_t            resp;
    } reg_rd_t;

    typedef struct packed {
        logic [data_w-1:0] data;
        resp_t             resp;
    } rd_rsp_t;

endpackage
